// File: src.f
+incdir+rtl
rtl/qspim_cfg_pkg.sv
rtl/qspim_cmd_pkg.sv
rtl/qspim_fifo.sv
rtl/qspim_req_decode.sv
rtl/qspim_seq.sv
rtl/qspim_resp.sv
rtl/qspim_top.sv
verification/qspim_flash_model.sv
verification/qspim_tb.sv

// File: Bender.yml
package:
  name: qspim

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/qspim_cfg_pkg.sv
      - rtl/qspim_cmd_pkg.sv
      - rtl/qspim_fifo.sv
      - rtl/qspim_req_decode.sv
      - rtl/qspim_seq.sv
      - rtl/qspim_resp.sv
      - rtl/qspim_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/qspim_flash_model.sv
      - verification/qspim_tb.sv

// File: verification/qspim_tb.sv
// Testbench for the quad SPI flash master
// Register checks, flash write rejection and a table of flash reads

`timescale 1ns/1ns
`include "qspim_consts.svh"

module qspim_tb;

    localparam int          N_TESTS  = 6;
    localparam logic [31:0] CTRL_ADR = {`QSPIM_REG_REGION, 24'h0, `QSPIM_REG_CTRL_OFS};
    localparam logic [31:0] CMD_ADR  = {`QSPIM_REG_REGION, 24'h0, `QSPIM_REG_CMD_OFS};

    // One flash read scenario
    typedef struct packed {
        qspim_cfg_pkg::spi_mode_e mode;
        logic [3:0]               dummy;
        logic [7:0]               clk_div;
        logic [7:0]               opcode;
        logic [23:0]              addr;
        logic                     rand_addr;   // Address comes from the LFSR
    } test_vec_t;

    test_vec_t   vec [N_TESTS];
    string       vec_name [N_TESTS];
    logic        mclk = 1'b0;
    logic        reset_i;
    logic        wbd_stb;
    logic [31:0] wbd_adr;
    logic        wbd_we;
    logic [31:0] wbd_dat;
    logic [3:0]  wbd_sel;
    logic [31:0] wbd_rdat;
    logic        wbd_ack;
    logic        wbd_err;
    logic        spi_clk;
    logic [3:0]  spi_csn;
    logic [3:0]  spi_sdo;
    logic [3:0]  spi_oen;
    logic [3:0]  spi_sdi;
    logic [7:0]  flash_opcode;
    logic [23:0] flash_addr;
    logic        flash_quad;
    logic [3:0]  model_dummy;
    logic [31:0] lfsr_state;
    logic [31:0] bus_rd;
    logic        bus_ack;
    logic        bus_err;
    int          low_cycles;       // mclk cycles with a chip select low
    int          base_low;

    qspim_top DUT (
        .mclk      (mclk),
        .reset_i   (reset_i),
        .wbd_stb_i (wbd_stb),
        .wbd_adr_i (wbd_adr),
        .wbd_we_i  (wbd_we),
        .wbd_dat_i (wbd_dat),
        .wbd_sel_i (wbd_sel),
        .wbd_dat_o (wbd_rdat),
        .wbd_ack_o (wbd_ack),
        .wbd_err_o (wbd_err),
        .spi_clk_o (spi_clk),
        .spi_csn_o (spi_csn),
        .spi_sdo_o (spi_sdo),
        .spi_oen_o (spi_oen),
        .spi_sdi_i (spi_sdi)
    );

    qspim_flash_model u_flash (
        .spi_clk_i (spi_clk),
        .spi_csn_i (spi_csn[0]),
        .spi_sdo_i (spi_sdo),
        .spi_oen_i (spi_oen),
        .dummy_i   (model_dummy),
        .spi_sdi_o (spi_sdi),
        .opcode_o  (flash_opcode),
        .addr_o    (flash_addr),
        .quad_o    (flash_quad)
    );

    always #4 mclk = ~mclk;        // 8 ns period

    always @(posedge mclk) begin
        if (reset_i)
            low_cycles <= 0;
        else if (spi_csn != 4'hF)
            low_cycles <= low_cycles + 1;
    end

    //------------------------------------------------------------
    // Helpers
    //------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] ctrl_word(input logic quad, input logic [3:0] dummy,
                                              input logic [7:0] div);
        return {15'd0, quad, 4'd0, dummy, div};
    endfunction

    // Flash pattern, first byte in bits 7:0
    function automatic logic [31:0] pattern_word(input logic [23:0] addr);
        logic [31:0] w;
        for (int k = 0; k < 4; k++)
            w[8*k +: 8] = (addr[7:0] + 8'(k)) ^ 8'hA5;
        return w;
    endfunction

    task automatic next_rand_addr(output logic [23:0] a);
        a = '0;
        for (int b = 0; b < 24; b++) begin
            lfsr_state = lfsr_next(lfsr_state);   // One step per bit
            a = {a[22:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    // Strobe held until ack or err, then dropped
    task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel, output logic [31:0] rdata,
                              output logic ack, output logic err);
        @(posedge mclk);
        #1;
        wbd_stb = 1'b1;
        wbd_we  = we;
        wbd_adr = adr;
        wbd_dat = dat;
        wbd_sel = sel;
        ack = 1'b0;
        err = 1'b0;
        while (!ack && !err) begin
            @(posedge mclk);
            #1;
            ack = wbd_ack;
            err = wbd_err;
        end
        rdata   = wbd_rdat;
        wbd_stb = 1'b0;
        wbd_we  = 1'b0;
    endtask

    task automatic reg_write(input string name, input logic [31:0] adr,
                             input logic [31:0] dat, input logic [3:0] sel);
        logic [31:0] rd;
        logic        a;
        logic        e;
        bus_access(1'b1, adr, dat, sel, rd, a, e);
        check_value({name, " ack"}, 32'd1, a);
    endtask

    task automatic reg_read(input string name, input logic [31:0] adr,
                            input logic [31:0] expected);
        logic [31:0] rd;
        logic        a;
        logic        e;
        bus_access(1'b0, adr, 32'd0, 4'hF, rd, a, e);
        check_value({name, " ack"}, 32'd1, a);
        check_value(name, expected, rd);
    endtask

    task automatic load_table();
        vec[0] = '{qspim_cfg_pkg::MODE_SINGLE, 4'd8,  8'd1, 8'h0B, 24'h012345, 1'b0};
        vec[1] = '{qspim_cfg_pkg::MODE_SINGLE, 4'd0,  8'd0, 8'h03, 24'h00A0FF, 1'b0};
        vec[2] = '{qspim_cfg_pkg::MODE_QUAD,   4'd6,  8'd1, 8'hEB, 24'h3C5A7E, 1'b0};
        vec[3] = '{qspim_cfg_pkg::MODE_QUAD,   4'd4,  8'd3, 8'h6B, 24'h000000, 1'b1};
        vec[4] = '{qspim_cfg_pkg::MODE_SINGLE, 4'd8,  8'd2, 8'h0B, 24'h000000, 1'b1};
        vec[5] = '{qspim_cfg_pkg::MODE_QUAD,   4'd10, 8'd0, 8'hEB, 24'h000000, 1'b1};
        vec_name[0] = "single_fast";
        vec_name[1] = "single_nodummy";
        vec_name[2] = "quad_dummy6";
        vec_name[3] = "quad_rand_div3";
        vec_name[4] = "single_rand_div2";
        vec_name[5] = "quad_rand_div0";
    endtask

    // Configure, read one word, compare with the flash pattern
    task automatic run_entry(input int i);
        test_vec_t   v;
        logic [31:0] rd;
        logic        a;
        logic        e;
        v = vec[i];
        if (v.rand_addr)
            next_rand_addr(v.addr);
        reg_write({vec_name[i], " ctrl"}, CTRL_ADR, ctrl_word(v.mode, v.dummy, v.clk_div), 4'hF);
        reg_write({vec_name[i], " cmd"}, CMD_ADR, {24'd0, v.opcode}, 4'h1);
        model_dummy = v.dummy;
        bus_access(1'b0, {8'h00, v.addr}, 32'd0, 4'hF, rd, a, e);
        check_value({vec_name[i], " ack"}, 32'd1, a);
        check_value({vec_name[i], " data"}, pattern_word(v.addr), rd);
        check_value({vec_name[i], " opcode"}, v.opcode, flash_opcode);
        check_value({vec_name[i], " addr"}, v.addr, flash_addr);
        check_value({vec_name[i], " quad"}, v.mode, flash_quad);
    endtask

    //------------------------------------------------------------
    // Main sequence
    //------------------------------------------------------------
    initial begin
        reset_i     = 1'b1;
        wbd_stb     = 1'b0;
        wbd_adr     = '0;
        wbd_we      = 1'b0;
        wbd_dat     = '0;
        wbd_sel     = '0;
        model_dummy = `QSPIM_RST_DUMMY;
        lfsr_state  = 32'hf1b880af;
        load_table();
        repeat (10) @(posedge mclk);
        #1 reset_i = 1'b0;

        // Idle outputs and reset values
        check_value("reset csn", 32'hF, spi_csn);
        check_value("reset spi clk", 32'd0, spi_clk);
        check_value("reset oen", 32'hF, spi_oen);
        check_value("reset ack", 32'd0, wbd_ack);
        check_value("reset err", 32'd0, wbd_err);
        reg_read("reset ctrl", CTRL_ADR, ctrl_word(1'b0, `QSPIM_RST_DUMMY, `QSPIM_RST_CLKDIV));
        reg_read("reset cmd", CMD_ADR, {24'd0, `QSPIM_RST_OPCODE});
        check_value("reset cs idle", 32'd0, low_cycles);

        // Byte-enabled register writes
        reg_write("ctrl full", CTRL_ADR, ctrl_word(1'b1, 4'd5, 8'd3), 4'b0111);
        reg_read("ctrl full", CTRL_ADR, ctrl_word(1'b1, 4'd5, 8'd3));
        reg_write("ctrl byte0", CTRL_ADR, ctrl_word(1'b0, 4'd9, 8'd2), 4'b0001);
        reg_read("ctrl byte0", CTRL_ADR, ctrl_word(1'b1, 4'd5, 8'd2));
        reg_write("ctrl byte12", CTRL_ADR, ctrl_word(1'b0, 4'd9, 8'd7), 4'b0110);
        reg_read("ctrl byte12", CTRL_ADR, ctrl_word(1'b0, 4'd9, 8'd2));
        reg_write("cmd masked", CMD_ADR, 32'h0000_00EB, 4'b0000);
        reg_read("cmd masked", CMD_ADR, {24'd0, `QSPIM_RST_OPCODE});
        reg_write("cmd byte0", CMD_ADR, 32'h0000_006B, 4'b0001);
        reg_read("cmd byte0", CMD_ADR, 32'h0000_006B);

        // Flash write gets err, no ack, no chip select
        base_low = low_cycles;
        bus_access(1'b1, 32'h0000_1000, 32'hDEAD_BEEF, 4'hF, bus_rd, bus_ack, bus_err);
        check_value("flash write err", 32'd1, bus_err);
        check_value("flash write ack", 32'd0, bus_ack);
        repeat (20) @(posedge mclk);
        #1;
        check_value("flash write cs", base_low, low_cycles);

        for (int i = 0; i < N_TESTS; i++)
            run_entry(i);

        $display("Finished with no errors");
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #(N_TESTS * 4000);
        $display("Timeout: the DUT did not answer a bus request in time");
        $display("Finished with errors");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: verification/qspim_flash_model.sv
// Behavioral quad SPI flash for the testbench
// Captures opcode and address, answers with an address-derived pattern

`timescale 1ns/1ns

module qspim_flash_model (
    input  logic        spi_clk_i,
    input  logic        spi_csn_i,
    input  logic [3:0]  spi_sdo_i,
    input  logic [3:0]  spi_oen_i,
    input  logic [3:0]  dummy_i,      // Dummy clocks to skip
    output logic [3:0]  spi_sdi_o,
    output logic [7:0]  opcode_o,
    output logic [23:0] addr_o,
    output logic        quad_o        // Quad address and data seen
);
    logic [31:0] stream;              // Outgoing bytes, first byte on top
    logic        quad_addr;
    int          n;

    initial begin
        spi_sdi_o = 4'hF;
        opcode_o  = '0;
        addr_o    = '0;
        quad_o    = 1'b0;
        forever begin
            @(negedge spi_csn_i);
            // Opcode is always single bit on DIO0
            for (n = 0; n < 8; n++) begin
                @(posedge spi_clk_i);
                opcode_o = {opcode_o[6:0], spi_sdo_i[0]};
            end
            @(posedge spi_clk_i);
            quad_addr = !spi_oen_i[1];    // DIO1 is driven by the master only in quad
            addr_o = quad_addr ? {20'd0, spi_sdo_i} : {23'd0, spi_sdo_i[0]};
            for (n = 1; n < (quad_addr ? 6 : 24); n++) begin
                @(posedge spi_clk_i);
                addr_o = quad_addr ? {addr_o[19:0], spi_sdo_i} : {addr_o[22:0], spi_sdo_i[0]};
            end
            repeat (dummy_i) @(posedge spi_clk_i);
            // Byte k is low address byte plus k, xor A5
            stream = {(addr_o[7:0] + 8'd0) ^ 8'hA5, (addr_o[7:0] + 8'd1) ^ 8'hA5,
                      (addr_o[7:0] + 8'd2) ^ 8'hA5, (addr_o[7:0] + 8'd3) ^ 8'hA5};
            quad_o = quad_addr;
            for (n = 0; n < (quad_addr ? 8 : 32); n++) begin
                @(negedge spi_clk_i);     // New bit after the falling edge
                spi_sdi_o = quad_addr ? stream[31:28] : {2'b11, stream[31], 1'b1};
                stream = quad_addr ? stream << 4 : stream << 1;
                @(posedge spi_clk_i);
                if (quad_addr && spi_oen_i != 4'hF)
                    quad_o = 1'b0;        // Master still driving the lines
            end
            @(negedge spi_clk_i);
            spi_sdi_o = 4'hF;
        end
    end

endmodule

// File: rtl/qspim_top.sv
// Quad SPI flash master top level
// Bus decoder, command and response FIFOs, sequencer and responder

`timescale 1ns/1ns
`include "qspim_consts.svh"

module qspim_top (
    input  logic        mclk,
    input  logic        reset_i,
    input  logic        wbd_stb_i,
    input  logic [31:0] wbd_adr_i,
    input  logic        wbd_we_i,
    input  logic [31:0] wbd_dat_i,
    input  logic [3:0]  wbd_sel_i,
    output logic [31:0] wbd_dat_o,
    output logic        wbd_ack_o,
    output logic        wbd_err_o,
    output logic        spi_clk_o,
    output logic [3:0]  spi_csn_o,
    output logic [3:0]  spi_sdo_o,
    output logic [3:0]  spi_oen_o,
    input  logic [3:0]  spi_sdi_i
);
    qspim_cfg_pkg::qspim_cfg_t cfg;
    qspim_cmd_pkg::qspim_cmd_t cmd_wdata;
    qspim_cmd_pkg::qspim_cmd_t cmd_rdata;
    logic        cmd_push, cmd_pop, cmd_full, cmd_empty;
    logic        res_push, res_pop, res_full, res_empty;
    logic [31:0] res_wdata, res_rdata;
    logic        reg_ack, rsp_ack, rsp_done, rd_pending;
    logic [31:0] reg_rdata, rsp_data;

    // Register and flash answers never overlap
    assign wbd_ack_o = reg_ack || rsp_ack;
    assign wbd_dat_o = rsp_ack ? rsp_data : reg_rdata;

    qspim_req_decode u_decode (
        .mclk, .reset_i, .wbd_stb_i, .wbd_adr_i, .wbd_we_i, .wbd_dat_i, .wbd_sel_i,
        .cmd_full_i   (cmd_full),
        .cmd_push_o   (cmd_push),
        .cmd_o        (cmd_wdata),
        .cfg_o        (cfg),
        .reg_ack_o    (reg_ack),
        .reg_rdata_o  (reg_rdata),
        .rd_pending_o (rd_pending),
        .rsp_done_i   (rsp_done),
        .wbd_err_o
    );

    qspim_fifo #(.WIDTH($bits(qspim_cmd_pkg::qspim_cmd_t)), .DEPTH(`QSPIM_CMD_DEPTH)) u_cmd_fifo (
        .mclk, .reset_i,
        .push_i (cmd_push), .wdata_i (cmd_wdata), .pop_i (cmd_pop),
        .rdata_o (cmd_rdata), .full_o (cmd_full), .empty_o (cmd_empty)
    );

    qspim_seq u_seq (
        .mclk, .reset_i,
        .cfg_i       (cfg),             // Divider is taken live
        .cmd_empty_i (cmd_empty), .cmd_i (cmd_rdata), .cmd_pop_o (cmd_pop),
        .res_full_i  (res_full), .res_push_o (res_push), .res_wdata_o (res_wdata),
        .spi_clk_o, .spi_csn_o, .spi_sdo_o, .spi_oen_o, .spi_sdi_i
    );

    qspim_fifo #(.WIDTH(32), .DEPTH(`QSPIM_RES_DEPTH)) u_res_fifo (
        .mclk, .reset_i,
        .push_i (res_push), .wdata_i (res_wdata), .pop_i (res_pop),
        .rdata_o (res_rdata), .full_o (res_full), .empty_o (res_empty)
    );

    qspim_resp u_resp (
        .mclk, .reset_i,
        .rd_pending_i (rd_pending), .res_empty_i (res_empty), .res_rdata_i (res_rdata),
        .res_pop_o    (res_pop),
        .rsp_ack_o    (rsp_ack), .rsp_data_o (rsp_data), .rsp_done_o (rsp_done)
    );

endmodule

// File: rtl/qspim_resp.sv
// Bus responder for flash reads
// Pops a read word and acks the pending bus request

`timescale 1ns/1ns

module qspim_resp (
    input  logic        mclk,
    input  logic        reset_i,
    input  logic        rd_pending_i,
    input  logic        res_empty_i,
    input  logic [31:0] res_rdata_i,
    output logic        res_pop_o,
    output logic        rsp_ack_o,
    output logic [31:0] rsp_data_o,
    output logic        rsp_done_o
);
    // One word per pending read, never during the ack cycle
    assign res_pop_o = rd_pending_i && !res_empty_i && !rsp_ack_o;

    always_ff @(posedge mclk) begin
        if (reset_i) begin
            rsp_ack_o  <= 1'b0;
            rsp_done_o <= 1'b0;
        end else begin
            rsp_ack_o  <= res_pop_o;
            rsp_done_o <= res_pop_o;    // Clears the decoder pending flag
        end
    end

    always_ff @(posedge mclk) begin
        if (res_pop_o)
            rsp_data_o <= res_rdata_i;
    end

    a_ack_pulse: assert property (@(posedge mclk) disable iff (reset_i)
        rsp_ack_o |=> !rsp_ack_o);

endmodule

// File: rtl/qspim_seq.sv
// SPI sequencer for one flash read per command
// Opcode, address, dummy and data phases with a programmable clock

`timescale 1ns/1ns

module qspim_seq (
    input  logic                      mclk,
    input  logic                      reset_i,
    input  qspim_cfg_pkg::qspim_cfg_t cfg_i,
    input  logic                      cmd_empty_i,
    input  qspim_cmd_pkg::qspim_cmd_t cmd_i,
    output logic                      cmd_pop_o,
    input  logic                      res_full_i,
    output logic                      res_push_o,
    output logic [31:0]               res_wdata_o,
    output logic                      spi_clk_o,
    output logic [3:0]                spi_csn_o,
    output logic [3:0]                spi_sdo_o,
    output logic [3:0]                spi_oen_o,
    input  logic [3:0]                spi_sdi_i
);
    qspim_cmd_pkg::seq_state_e state;
    qspim_cmd_pkg::seq_state_e nxt_state;
    qspim_cmd_pkg::qspim_cmd_t cmd_q;
    logic [7:0]                div_cnt;     // Half-period counter
    logic [5:0]                bit_cnt;     // SPI clocks left in phase
    logic [5:0]                nxt_cnt;
    logic [5:0]                data_cnt;
    logic [31:0]               sh_out;      // Opcode then address, MSB first
    logic [31:0]               sh_in;
    logic                      active;
    logic                      tick;
    logic                      quad;

    assign quad      = (cmd_q.mode == qspim_cfg_pkg::MODE_QUAD);
    assign active    = state inside {qspim_cmd_pkg::SEQ_CMD, qspim_cmd_pkg::SEQ_ADDR,
                                     qspim_cmd_pkg::SEQ_DUMMY, qspim_cmd_pkg::SEQ_DATA};
    assign tick      = active && (div_cnt == cfg_i.clk_div);   // Edge of spi_clk
    assign cmd_pop_o = (state == qspim_cmd_pkg::SEQ_IDLE) && !cmd_empty_i;
    assign res_push_o = (state == qspim_cmd_pkg::SEQ_DONE) && !res_full_i;
    assign data_cnt  = quad ? 6'd7 : 6'd31;
    // First byte received sits in bits 7:0
    assign res_wdata_o = {sh_in[7:0], sh_in[15:8], sh_in[23:16], sh_in[31:24]};

    //------------------------------------------------------------
    // Phase sequencing
    //------------------------------------------------------------
    always_comb begin
        nxt_state = qspim_cmd_pkg::SEQ_DONE;
        nxt_cnt   = '0;
        case (state)
            qspim_cmd_pkg::SEQ_CMD: begin
                nxt_state = qspim_cmd_pkg::SEQ_ADDR;
                nxt_cnt   = quad ? 6'd5 : 6'd23;     // 24 address bits
            end
            qspim_cmd_pkg::SEQ_ADDR: begin
                if (cmd_q.dummy != 4'd0) begin
                    nxt_state = qspim_cmd_pkg::SEQ_DUMMY;
                    nxt_cnt   = {2'b00, cmd_q.dummy} - 6'd1;
                end else begin
                    nxt_state = qspim_cmd_pkg::SEQ_DATA;
                    nxt_cnt   = data_cnt;
                end
            end
            qspim_cmd_pkg::SEQ_DUMMY: begin
                nxt_state = qspim_cmd_pkg::SEQ_DATA;
                nxt_cnt   = data_cnt;
            end
            default: ;  // DATA ends in DONE
        endcase
    end

    always_ff @(posedge mclk) begin
        if (reset_i) begin
            state     <= qspim_cmd_pkg::SEQ_IDLE;
            spi_clk_o <= 1'b0;
            spi_csn_o <= 4'hF;
            div_cnt   <= '0;
            bit_cnt   <= '0;
        end else begin
            case (state)
                qspim_cmd_pkg::SEQ_IDLE: if (cmd_pop_o) begin
                    state     <= qspim_cmd_pkg::SEQ_CMD;
                    spi_csn_o <= 4'hE;      // Only CS0 is used
                    bit_cnt   <= 6'd7;      // 8 opcode clocks
                    div_cnt   <= '0;
                end
                qspim_cmd_pkg::SEQ_DONE: if (!res_full_i) state <= qspim_cmd_pkg::SEQ_IDLE;
                default: begin
                    div_cnt <= tick ? '0 : div_cnt + 1'b1;
                    if (tick) begin
                        spi_clk_o <= !spi_clk_o;
                        if (spi_clk_o) begin            // Falling edge closes a clock
                            bit_cnt <= bit_cnt - 1'b1;
                            if (bit_cnt == '0) begin
                                state   <= nxt_state;
                                bit_cnt <= nxt_cnt;
                                if (state == qspim_cmd_pkg::SEQ_DATA)
                                    spi_csn_o <= 4'hF;  // Half-period after last sample
                            end
                        end
                    end
                end
            endcase
        end
    end

    // Shifters, output moves on falling and input on rising edge
    always_ff @(posedge mclk) begin
        if (cmd_pop_o) begin
            cmd_q  <= cmd_i;
            sh_out <= {cmd_i.opcode, cmd_i.addr};
        end else if (tick && spi_clk_o) begin
            sh_out <= (quad && state == qspim_cmd_pkg::SEQ_ADDR) ? sh_out << 4 : sh_out << 1;
        end
        if (tick && !spi_clk_o && state == qspim_cmd_pkg::SEQ_DATA)
            sh_in <= quad ? {sh_in[27:0], spi_sdi_i} : {sh_in[30:0], spi_sdi_i[1]};
    end

    //------------------------------------------------------------
    // Pad drive
    //------------------------------------------------------------
    always_comb begin
        spi_sdo_o = 4'b1100;        // WP# and HOLD# high
        spi_oen_o = 4'b1111;        // Released in idle
        if (active) begin
            spi_sdo_o[0] = sh_out[31];
            spi_oen_o    = 4'b0010;  // DIO1 is the single-mode input
            if (quad && state == qspim_cmd_pkg::SEQ_ADDR) begin
                spi_sdo_o = sh_out[31:28];
                spi_oen_o = 4'b0000;
            end else if (quad && state != qspim_cmd_pkg::SEQ_CMD) begin
                spi_oen_o = 4'b1111;   // Flash drives dummy and data
            end
        end
    end

    a_csn_idle: assert property (@(posedge mclk) disable iff (reset_i)
        state == qspim_cmd_pkg::SEQ_IDLE |-> spi_csn_o == 4'hF);

endmodule

// File: rtl/qspim_req_decode.sv
// Bus request decoder with the configuration registers
// Answers register accesses and flash writes, queues flash reads

`timescale 1ns/1ns
`include "qspim_consts.svh"

module qspim_req_decode (
    input  logic                      mclk,
    input  logic                      reset_i,
    input  logic                      wbd_stb_i,
    input  logic [31:0]               wbd_adr_i,
    input  logic                      wbd_we_i,
    input  logic [31:0]               wbd_dat_i,
    input  logic [3:0]                wbd_sel_i,
    input  logic                      cmd_full_i,
    output logic                      cmd_push_o,
    output qspim_cmd_pkg::qspim_cmd_t cmd_o,
    output qspim_cfg_pkg::qspim_cfg_t cfg_o,
    output logic                      reg_ack_o,
    output logic [31:0]               reg_rdata_o,
    output logic                      rd_pending_o,
    input  logic                      rsp_done_i,
    output logic                      wbd_err_o
);
    qspim_cmd_pkg::reg_sel_e reg_sel;
    logic                    is_reg;    // Register region hit
    logic                    req_new;   // Strobe not yet served
    logic                    rd_go;     // Flash read accepted this cycle

    assign is_reg  = (wbd_adr_i[31:28] == `QSPIM_REG_REGION);
    assign req_new = wbd_stb_i && !reg_ack_o && !wbd_err_o && !rd_pending_o;
    assign rd_go   = req_new && !is_reg && !wbd_we_i && !cmd_full_i;   // Held on back-pressure

    always_comb begin
        reg_sel = qspim_cmd_pkg::REG_NONE;
        if (wbd_adr_i[3:0] == `QSPIM_REG_CTRL_OFS)
            reg_sel = qspim_cmd_pkg::REG_CTRL;
        else if (wbd_adr_i[3:0] == `QSPIM_REG_CMD_OFS)
            reg_sel = qspim_cmd_pkg::REG_CMD;
    end

    //------------------------------------------------------------
    // Handshake flags and configuration registers
    //------------------------------------------------------------
    always_ff @(posedge mclk) begin
        if (reset_i) begin
            cfg_o        <= '{mode:    qspim_cfg_pkg::MODE_SINGLE,
                              dummy:   `QSPIM_RST_DUMMY,
                              clk_div: `QSPIM_RST_CLKDIV,
                              opcode:  `QSPIM_RST_OPCODE};
            reg_ack_o    <= 1'b0;
            wbd_err_o    <= 1'b0;
            cmd_push_o   <= 1'b0;
            rd_pending_o <= 1'b0;
        end else begin
            reg_ack_o  <= req_new && is_reg;
            wbd_err_o  <= req_new && !is_reg && wbd_we_i;   // Flash is read only
            cmd_push_o <= rd_go;
            if (rsp_done_i)
                rd_pending_o <= 1'b0;
            else if (rd_go)
                rd_pending_o <= 1'b1;
            // Byte-enabled register writes
            if (req_new && is_reg && wbd_we_i) begin
                if (reg_sel == qspim_cmd_pkg::REG_CTRL) begin
                    if (wbd_sel_i[0]) cfg_o.clk_div <= wbd_dat_i[7:0];
                    if (wbd_sel_i[1]) cfg_o.dummy   <= wbd_dat_i[11:8];
                    if (wbd_sel_i[2]) cfg_o.mode    <= qspim_cfg_pkg::spi_mode_e'(wbd_dat_i[16]);
                end else if (reg_sel == qspim_cmd_pkg::REG_CMD && wbd_sel_i[0]) begin
                    cfg_o.opcode <= wbd_dat_i[7:0];
                end
            end
        end
    end

    // Command snapshot and read-back data
    always_ff @(posedge mclk) begin
        if (rd_go) begin
            cmd_o.addr   <= wbd_adr_i[23:0];
            cmd_o.opcode <= cfg_o.opcode;
            cmd_o.mode   <= cfg_o.mode;
            cmd_o.dummy  <= cfg_o.dummy;
        end
        case (reg_sel)
            qspim_cmd_pkg::REG_CTRL: reg_rdata_o <= {15'd0, cfg_o.mode, 4'd0, cfg_o.dummy,
                                                      cfg_o.clk_div};
            qspim_cmd_pkg::REG_CMD:  reg_rdata_o <= {24'd0, cfg_o.opcode};
            default:                 reg_rdata_o <= '0;
        endcase
    end

    a_ack_err_excl: assert property (@(posedge mclk) disable iff (reset_i)
        !(reg_ack_o && wbd_err_o));

endmodule

// File: rtl/qspim_fifo.sv
// Synchronous FIFO for the command and response queues
// Head entry is visible on rdata_o while not empty

`timescale 1ns/1ns

module qspim_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             mclk,
    input  logic             reset_i,
    input  logic             push_i,
    input  logic [WIDTH-1:0] wdata_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] rdata_o,
    output logic             full_o,
    output logic             empty_o
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;        // Occupancy 0..DEPTH
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign full_o  = (count == (AW+1)'(DEPTH));
    assign empty_o = (count == '0);
    assign rdata_o = mem[rd_ptr];

    always_ff @(posedge mclk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;   // Wrap
            if (do_pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            if (do_push != do_pop)
                count <= do_push ? count + 1'b1 : count - 1'b1;
        end
    end

    // Storage
    always_ff @(posedge mclk) begin
        if (do_push)
            mem[wr_ptr] <= wdata_i;
    end

    // Producers and consumers must honour the flags
    a_no_push_full: assert property (@(posedge mclk) disable iff (reset_i)
        !(push_i && full_o));
    a_no_pop_empty: assert property (@(posedge mclk) disable iff (reset_i)
        !(pop_i && empty_o));

endmodule

// File: rtl/qspim_cmd_pkg.sv
// Quad SPI master command types
// Queued flash read, sequencer phases and register select

package qspim_cmd_pkg;

    //------------------------------------------------------------
    // One queued flash read, 37 bits
    //------------------------------------------------------------
    typedef struct packed {
        logic [23:0]              addr;     // Flash byte address
        logic [7:0]               opcode;   // Snapshot at request time
        qspim_cfg_pkg::spi_mode_e mode;
        logic [3:0]               dummy;
    } qspim_cmd_t;

    // Sequencer phases
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_CMD,        // Opcode, always single bit
        SEQ_ADDR,
        SEQ_DUMMY,
        SEQ_DATA,
        SEQ_DONE        // Waits for room in the response FIFO
    } seq_state_e;

    // Decoded register target
    typedef enum logic [1:0] {
        REG_CTRL,
        REG_CMD,
        REG_NONE        // Unmapped offset, reads as zero
    } reg_sel_e;

endpackage

// File: rtl/qspim_cfg_pkg.sv
// Quad SPI master configuration types
// SPI line mode and the live configuration bundle

package qspim_cfg_pkg;

    // Width of address, dummy and data phases
    typedef enum logic {
        MODE_SINGLE = 1'b0,     // One bit per clock on DIO0/DIO1
        MODE_QUAD   = 1'b1      // Nibble per clock on DIO3..0
    } spi_mode_e;

    //------------------------------------------------------------
    // Live configuration, 21 bits
    //------------------------------------------------------------
    typedef struct packed {
        spi_mode_e   mode;
        logic [3:0]  dummy;     // Dummy phase length in SPI clocks
        logic [7:0]  clk_div;   // Half-period is clk_div+1 mclk cycles
        logic [7:0]  opcode;    // Flash read opcode
    } qspim_cfg_t;

endpackage

// File: rtl/qspim_consts.svh
// Quad SPI master constants
// FIFO depths, register map and configuration reset values

`ifndef QSPIM_CONSTS_SVH
`define QSPIM_CONSTS_SVH

// FIFO sizing
`define QSPIM_CMD_DEPTH     4
`define QSPIM_RES_DEPTH     8

// Address bits 31:28 that select the register region
`define QSPIM_REG_REGION    4'hF
`define QSPIM_REG_CTRL_OFS  4'h0    // Control register
`define QSPIM_REG_CMD_OFS   4'h4    // Command register

// Configuration after reset
`define QSPIM_RST_OPCODE    8'h0B   // Fast read
`define QSPIM_RST_DUMMY     4'd8
`define QSPIM_RST_CLKDIV    8'd1

`endif
